/* flist.f */
source/gauntlet_pkg.sv
source/rom_bank.sv
source/rom_download.sv
source/game_rom_store.sv
source/key_latch.sv
source/joystick_router.sv
source/gauntlet_io_shell.sv
tb/tb_clock.sv
tb/tb_gauntlet_io_shell.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, verdict from the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_gauntlet_io_shell -f flist.f

./obj_dir/Vtb_gauntlet_io_shell | tee sim.log

if grep -qx '\*\* PASS \*\*' sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi

/* tb/tb_gauntlet_io_shell.sv */
/*
 Testbench of the Gauntlet host glue
 Random stimulus from a fixed seed, ROM images and key bits modelled here
 Only written ROM addresses are compared, unwritten bank words are undefined
 Stops at the first mismatch
*/
`timescale 1ns/100ps

module tb_gauntlet_io_shell;

	localparam int N_MP = 16; // Random pairs per program region
	localparam int N_BY = 24; // Random bytes per byte region
	localparam int N_IN = 40; // Input steps per game type
	localparam int TEST_CYCLES = 6 * (N_MP + 1) * 6 + 3 * (N_BY + 1) * 4
		+ 6 * (N_MP + 1) * 2 + 2 * N_IN * 3 + (16 + N_IN) * 3 + 160;
	localparam int LIMIT = 2 * TEST_CYCLES;

	// Program regions: loader base, bus base, word count
	localparam int MP_LDR [6] = '{'h0C0000, 'h0F0000, 'h100000, 'h110000, 'h120000, 'h130000};
	localparam int MP_BUS [6] = '{'h00000, 'h18000, 'h20000, 'h28000, 'h30000, 'h38000};
	localparam int MP_WORDS [6] = '{'h8000, 'h4000, 'h8000, 'h8000, 'h8000, 'h8000};

	// Key maps, bit index into the flat key vector (kp1 at 35..28, coins at 3..0)
	localparam logic [8:0] G_CODE [28] = '{9'h175, 9'h172, 9'h16B, 9'h174, 9'h014, 9'h011,
		9'h02D, 9'h02B, 9'h023, 9'h034, 9'h01C, 9'h01B, 9'h043, 9'h042, 9'h03B, 9'h04B,
		9'h114, 9'h059, 9'h075, 9'h072, 9'h06B, 9'h074, 9'h070, 9'h071,
		9'h02E, 9'h036, 9'h03D, 9'h03E};
	localparam int G_BIT [28] = '{35, 34, 33, 32, 29, 28, 27, 26, 25, 24, 21, 20,
		19, 18, 17, 16, 13, 12, 11, 10, 9, 8, 5, 4, 0, 1, 2, 3};
	localparam logic [8:0] V_CODE [20] = '{9'h023, 9'h01B, 9'h024, 9'h01D, 9'h02D, 9'h015,
		9'h02B, 9'h01C, 9'h042, 9'h03B, 9'h043, 9'h03C, 9'h044, 9'h035, 9'h04B, 9'h033,
		9'h016, 9'h01E, 9'h02E, 9'h036};
	localparam int V_BIT [20] = '{35, 34, 33, 32, 31, 30, 29, 28, 27, 26, 25, 24,
		23, 22, 21, 20, 12, 13, 0, 1};

	logic clk_sys;
	logic rst_por;
	logic rst_mid;
	logic rst;
	logic ioctl_download;
	logic ioctl_wr;
	logic [7:0] ioctl_index;
	logic [24:0] ioctl_addr;
	logic [7:0] ioctl_dout;
	logic [10:0] ps2_key;
	gauntlet_pkg::joy_t [3:0] joystick;
	gauntlet_pkg::seat_map_t seat_map;
	logic service;
	logic [18:0] mp_addr;
	logic [15:0] mp_data;
	logic [15:0] ap_addr;
	logic [7:0] ap_data;
	logic [13:0] cp_addr;
	logic [7:0] cp_data;
	gauntlet_pkg::game_type_e game_type;
	gauntlet_pkg::player_ports_t player_ports;

	integer seed = 32'hee7fac0d;
	int cycles = 0;
	logic tog = 1'b0;           // Keyboard toggle bit
	logic [35:0] key_model = '0;
	logic [7:0] cur_gt = 8'd104;
	logic [15:0] mp_model [int];
	logic [7:0] ap_model [int];
	logic [7:0] cp_model [int];

	assign rst = rst_por | rst_mid;

	tb_clock tb_clock_inst (.clk_sys(clk_sys), .rst(rst_por));

	gauntlet_io_shell gauntlet_io_shell_inst (
		.clk_sys(clk_sys), .rst(rst), .ioctl_download(ioctl_download), .ioctl_wr(ioctl_wr),
		.ioctl_index(ioctl_index), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.ps2_key(ps2_key), .joystick(joystick), .seat_map(seat_map), .service(service),
		.mp_addr(mp_addr), .mp_data(mp_data), .ap_addr(ap_addr), .ap_data(ap_data),
		.cp_addr(cp_addr), .cp_data(cp_data), .game_type(game_type),
		.player_ports(player_ports)
	);

	// ##################################################
	// Helpers
	// ##################################################
	task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			$display("Mismatch %s expected %h actual %h", name, exp, act);
			$display("** FAIL **");
			$fatal(1, "Check failed");
		end
	endtask

	// One loader byte, strobe high for one cycle
	task automatic loader_write(input logic dl, input logic [7:0] idx, input int addr,
		input logic [7:0] data);
		@(posedge clk_sys);
		ioctl_download <= dl;
		ioctl_wr       <= 1'b1;
		ioctl_index    <= idx;
		ioctl_addr     <= 25'(addr);
		ioctl_dout     <= data;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
	endtask

	task automatic read_buses(input int ma, input int aa, input int ca,
		output logic [15:0] md, output logic [7:0] ad, output logic [7:0] cd);
		@(posedge clk_sys);
		mp_addr <= 19'(ma);
		ap_addr <= 16'(aa);
		cp_addr <= 14'(ca);
		@(posedge clk_sys);
		@(negedge clk_sys); // Data settled one edge after the address
		md = mp_data;
		ad = ap_data;
		cd = cp_data;
	endtask

	task automatic check_program_rom(input string name);
		logic [15:0] md;
		logic [7:0] ad;
		logic [7:0] cd;
		foreach (mp_model[a]) begin
			read_buses(a, 0, 0, md, ad, cd);
			check(name, mp_model[a], md);
		end
	endtask

	task automatic set_game_type(input logic [7:0] gt);
		loader_write(1'b1, 8'd1, 'h0C0001, gt); // Word 0 of 9AB holds known data
		@(negedge clk_sys);
		check("game_type", gt, game_type);
		cur_gt = gt;
	endtask

	// Tread bits {right back, left back, right fwd, left fwd} from up, down, left, right
	function automatic logic [3:0] tread(input logic [3:0] d);
		logic up;
		logic upr;
		logic rt;
		logic dnr;
		logic dn;
		logic dnl;
		logic lt;
		logic upl;
		up  = d == 4'b1000;
		upr = d == 4'b1001;
		rt  = d == 4'b0001;
		dnr = d == 4'b0101;
		dn  = d == 4'b0100;
		dnl = d == 4'b0110;
		lt  = d == 4'b0010;
		upl = d == 4'b1010;
		tread = {rt | dn | dnl, dnr | dn | lt, upl | up | lt, up | upr | rt};
	endfunction

	function automatic gauntlet_pkg::player_ports_t expected_ports(
		input gauntlet_pkg::joy_t [3:0] js, input gauntlet_pkg::seat_map_t sm,
		input logic svc, input logic [7:0] gt, input logic [35:0] kv);
		gauntlet_pkg::key_state_t ks;
		gauntlet_pkg::joy_t s [4];
		logic [1:0] sel [4];
		logic [7:0] pb [4];
		gauntlet_pkg::player_ports_t pp;
		logic four;
		ks = kv;
		sel = '{sm.warrior, sm.valkyrie, sm.wizard, sm.elf};
		four = gt == 8'd104 || gt == 8'd106;
		for (int k = 0; k < 4; k++) begin
			s[k] = four ? js[(k + int'(sel[k])) % 4] : js[k];
			pb[k] = {s[k].up, s[k].down, s[k].left, s[k].right,
				s[k].button4, s[k].button3, s[k].button2, s[k].button1};
		end
		if (gt == 8'd118) begin
			pp.p1 = ~(ks.kp1 | {tread(pb[0][7:4]), pb[0][3:0]});
			pp.p2 = ~(ks.kp2 | {tread(pb[1][7:4]), pb[1][3:0]});
			pp.p3 = ~(ks.kp3 | {6'b0, s[1].start, s[0].start});
			pp.p4 = ~ks.kp4;
		end else begin
			pp.p1 = ~(ks.kp1 | pb[0]);
			pp.p2 = ~(ks.kp2 | pb[1]);
			pp.p3 = ~(ks.kp3 | pb[2]);
			pp.p4 = ~(ks.kp4 | pb[3]);
		end
		pp.sys = {~svc, ~(ks.coin[0] | s[0].coin), ~(ks.coin[1] | s[1].coin),
			~(ks.coin[2] | s[2].coin), ~(ks.coin[3] | s[3].coin)};
		return pp;
	endfunction

	// Random inputs plus one key event, dir >= 0 forces seats 0 and 1 directions
	task automatic input_step(input string name, input int dir);
		gauntlet_pkg::joy_t [3:0] js;
		gauntlet_pkg::seat_map_t sm;
		logic svc;
		logic pr;
		logic [8:0] code;
		int e;
		int bitn;
		for (int k = 0; k < 4; k++)
			js[k] = 10'($random(seed));
		if (dir >= 0) begin
			{js[0].up, js[0].down, js[0].left, js[0].right} = 4'(dir);
			{js[1].up, js[1].down, js[1].left, js[1].right} = 4'(dir);
		end
		sm = 8'($random(seed));
		svc = 1'($random(seed));
		pr = 1'($random(seed));
		code = 9'h000; // Unmapped
		bitn = -1;
		if (cur_gt == 8'd118) begin
			e = {$random(seed)} % 21;
			if (e < 20) begin
				code = V_CODE[e];
				bitn = V_BIT[e];
			end
		end else begin
			e = {$random(seed)} % 29;
			if (e < 28) begin
				code = G_CODE[e];
				bitn = G_BIT[e];
			end
		end
		tog = ~tog;
		if (bitn >= 0)
			key_model[bitn] = pr;
		@(posedge clk_sys);
		joystick <= js;
		seat_map <= sm;
		service  <= svc;
		ps2_key  <= {tog, pr, code};
		@(posedge clk_sys);
		@(posedge clk_sys);
		@(negedge clk_sys);
		check(name, expected_ports(js, sm, svc, cur_gt, key_model), player_ports);
	endtask

	// ##################################################
	// Timeout
	// ##################################################
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles > LIMIT) begin
			$display("Timeout, the run did not finish within %0d cycles", LIMIT);
			$display("** FAIL **");
			$fatal(1, "Timeout");
		end
	end

	// ##################################################
	// Tests
	// ##################################################
	initial begin
		logic [15:0] md;
		logic [7:0] ad;
		logic [7:0] cd;
		logic [7:0] hi;
		logic [7:0] lo;
		int w;
		int k;
		gauntlet_pkg::player_ports_t rp;

		rst_mid = 1'b0;
		ioctl_download = 1'b1;
		ioctl_wr = 1'b0;
		ioctl_index = 8'd0;
		ioctl_addr = '0;
		ioctl_dout = 8'd0;
		ps2_key = '0;
		joystick = '0;
		seat_map = '0;
		service = 1'b0;
		mp_addr = '0;
		ap_addr = '0;
		cp_addr = '0;
		@(negedge rst_por);

		// Program download, word 0 always first
		for (int r = 0; r < 6; r++) begin
			for (int n = 0; n <= N_MP; n++) begin
				w = (n == 0) ? 0 : {$random(seed)} % MP_WORDS[r];
				hi = 8'($random(seed));
				lo = 8'($random(seed));
				loader_write(1'b1, 8'd0, MP_LDR[r] + 2 * w, hi);
				loader_write(1'b1, 8'd0, MP_LDR[r] + 2 * w + 1, lo);
				mp_model[MP_BUS[r] + w] = {hi, lo};
			end
		end
		check_program_rom("program_rom");
		read_buses('h08000 + {$random(seed)} % 'h8000, 0, 0, md, ad, cd); // Block 1 gap
		check("program_gap", 16'h0, md);
		read_buses('h1C000 + {$random(seed)} % 'h4000, 0, 0, md, ad, cd); // Above 10AB
		check("program_gap", 16'h0, md);

		// Audio and character download
		for (int n = 0; n <= N_BY; n++) begin
			w = {$random(seed)} % 'h8000;
			hi = 8'($random(seed));
			loader_write(1'b1, 8'd0, 'h140000 + w, hi);
			ap_model['h8000 + w] = hi; // 16S on bit 15 high
			w = {$random(seed)} % 'h4000;
			hi = 8'($random(seed));
			loader_write(1'b1, 8'd0, 'h148000 + w, hi);
			ap_model[w] = hi;
			w = {$random(seed)} % 'h4000;
			hi = 8'($random(seed));
			loader_write(1'b1, 8'd0, 'h14C000 + w, hi);
			cp_model[w] = hi;
		end
		void'(ap_model.first(k));
		loader_write(1'b0, 8'd0, (k >= 'h8000) ? 'h140000 + k - 'h8000 : 'h148000 + k,
			~ap_model[k]); // Outside a download
		void'(cp_model.first(k));
		loader_write(1'b0, 8'd0, 'h14C000 + k, ~cp_model[k]);
		foreach (ap_model[a]) begin
			read_buses(0, a, 0, md, ad, cd);
			check("audio_rom", ap_model[a], ad);
		end
		foreach (cp_model[a]) begin
			read_buses(0, 0, a, md, ad, cd);
			check("char_rom", cp_model[a], cd);
		end

		// Game type under index 1
		set_game_type(8'd106);
		set_game_type(8'd107);
		set_game_type(8'd118);
		set_game_type(8'd104);
		check_program_rom("rom_after_index1");

		// Gauntlet inputs, four players then two
		for (int n = 0; n < N_IN; n++)
			input_step("gauntlet_4p", -1);
		set_game_type(8'd107);
		for (int n = 0; n < N_IN; n++)
			input_step("gauntlet_2p", -1);

		// Vindicators, every direction combination
		set_game_type(8'd118);
		for (int d = 0; d < 16; d++)
			input_step("vindicators", d);

		// Reset in mid run
		@(posedge clk_sys);
		rst_mid <= 1'b1;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		rp = '1;
		rp.sys[4] = ~service;
		check("ports_in_reset", rp, player_ports);
		@(posedge clk_sys);
		rst_mid <= 1'b0;
		key_model = '0;
		cur_gt = 8'd104;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check("game_type_after_reset", 8'd104, game_type);
		check("ports_after_reset",
			expected_ports(joystick, seat_map, service, cur_gt, key_model), player_ports);
		input_step("after_reset", -1);

		$display("** PASS **");
		$finish;
	end

endmodule

/* tb/tb_clock.sv */
/*
 Testbench clock and power-on reset
 100 ns period, reset high for the first 5 rising edges
*/
`timescale 1ns/100ps

module tb_clock (
	output logic clk_sys,
	output logic rst
);

	initial begin
		clk_sys = 1'b0;
		rst     = 1'b1;
		repeat (5) @(posedge clk_sys);
		rst <= 1'b0; // Released on an edge
	end

	always #50 clk_sys = ~clk_sys;

endmodule

/* source/gauntlet_io_shell.sv */
/*
 Host glue of the Gauntlet core, ROM download and player inputs
 Loader strobes reach the ROM banks after two cycles
 Keyboard events reach player_ports after two cycles, joysticks after one
*/
`timescale 1ns/100ps

module gauntlet_io_shell (
	input  logic                        clk_sys,
	input  logic                        rst,
	input  logic                        ioctl_download,
	input  logic                        ioctl_wr,
	input  logic [7:0]                  ioctl_index,
	input  logic [24:0]                 ioctl_addr,
	input  logic [7:0]                  ioctl_dout,
	input  logic [10:0]                 ps2_key,
	input  gauntlet_pkg::joy_t [3:0]    joystick,
	input  gauntlet_pkg::seat_map_t     seat_map,
	input  logic                        service,
	input  logic [18:0]                 mp_addr,
	output logic [15:0]                 mp_data,
	input  logic [15:0]                 ap_addr,
	output logic [7:0]                  ap_data,
	input  logic [13:0]                 cp_addr,
	output logic [7:0]                  cp_data,
	output gauntlet_pkg::game_type_e    game_type,
	output gauntlet_pkg::player_ports_t player_ports
);

	localparam int ROM_AW_MP = 15; // 32K words per program pair

	gauntlet_pkg::rom_wr_t rom_wr;
	gauntlet_pkg::key_state_t keys;

	// ##################################################
	// ROM path
	// ##################################################
	rom_download rom_download_inst (
		.clk_sys        (clk_sys),
		.rst            (rst),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.rom_wr         (rom_wr),
		.game_type      (game_type)
	);

	game_rom_store #(.ROM_AW_MP(ROM_AW_MP)) game_rom_store_inst (
		.clk_sys (clk_sys),
		.rst     (rst),
		.rom_wr  (rom_wr),
		.mp_addr (mp_addr),
		.mp_data (mp_data),
		.ap_addr (ap_addr),
		.ap_data (ap_data),
		.cp_addr (cp_addr),
		.cp_data (cp_data)
	);

	// ##################################################
	// Input path
	// ##################################################
	key_latch key_latch_inst (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.ps2_key   (ps2_key),
		.game_type (game_type),
		.keys      (keys)
	);

	joystick_router joystick_router_inst (
		.clk_sys      (clk_sys),
		.rst          (rst),
		.joystick     (joystick),
		.seat_map     (seat_map),
		.service      (service),
		.game_type    (game_type),
		.keys         (keys),
		.player_ports (player_ports)
	);

endmodule

/* source/joystick_router.sv */
/*
 Joysticks and held keys to the active-low player ports
 Seat remap only in the four player games
 Vindicators Part II turns seats 1 and 2 into tank tread commands
 All outputs registered, one cycle from any input
*/
`timescale 1ns/100ps

module joystick_router (
	input  logic                        clk_sys,
	input  logic                        rst,
	input  gauntlet_pkg::joy_t [3:0]    joystick,
	input  gauntlet_pkg::seat_map_t     seat_map,
	input  logic                        service,
	input  gauntlet_pkg::game_type_e    game_type,
	input  gauntlet_pkg::key_state_t    keys,
	output gauntlet_pkg::player_ports_t player_ports
);

	gauntlet_pkg::joy_t [3:0] seat;
	gauntlet_pkg::player_ports_t ports_d;
	logic [1:0] sel [4];
	logic four_p;
	logic vind;

	// Gauntlet byte, directions high and buttons low
	function automatic logic [7:0] gbyte(input gauntlet_pkg::joy_t j);
		gbyte = {j.up, j.down, j.left, j.right, j.button4, j.button3, j.button2, j.button1};
	endfunction

	// Tread bits {right back, left back, right fwd, left fwd}
	function automatic logic [3:0] tank(input gauntlet_pkg::joy_t j);
		case ({j.up, j.down, j.left, j.right})
			4'b1010: tank = 4'b0010; // Up-left
			4'b1000: tank = 4'b0011; // Up
			4'b1001: tank = 4'b0001; // Up-right
			4'b0001: tank = 4'b1001; // Right, spin
			4'b0101: tank = 4'b0100; // Down-right
			4'b0100: tank = 4'b1100; // Down
			4'b0110: tank = 4'b1000; // Down-left
			4'b0010: tank = 4'b0110; // Left, spin
			default: tank = 4'b0000;
		endcase
	endfunction

	assign four_p = game_type inside {gauntlet_pkg::GT_GAUNTLET, gauntlet_pkg::GT_GAUNTLET2};
	assign vind   = game_type == gauntlet_pkg::GT_VINDICATORS2;

	assign sel[0] = seat_map.warrior;
	assign sel[1] = seat_map.valkyrie;
	assign sel[2] = seat_map.wizard;
	assign sel[3] = seat_map.elf;

	always_comb begin
		for (int k = 0; k < 4; k++)
			seat[k] = four_p ? joystick[(k + sel[k]) % 4] : joystick[k];

		if (vind) begin
			ports_d.p1 = ~(keys.kp1 | {tank(seat[0]), 4'(gbyte(seat[0]))}); // Buttons low
			ports_d.p2 = ~(keys.kp2 | {tank(seat[1]), 4'(gbyte(seat[1]))});
			ports_d.p3 = ~(keys.kp3 | {6'b0, seat[1].start, seat[0].start});
			ports_d.p4 = ~keys.kp4; // Keys only
		end else begin
			ports_d.p1 = ~(keys.kp1 | gbyte(seat[0]));
			ports_d.p2 = ~(keys.kp2 | gbyte(seat[1]));
			ports_d.p3 = ~(keys.kp3 | gbyte(seat[2]));
			ports_d.p4 = ~(keys.kp4 | gbyte(seat[3]));
		end
		ports_d.sys = {~service,
			~(keys.coin[0] | seat[0].coin), ~(keys.coin[1] | seat[1].coin),
			~(keys.coin[2] | seat[2].coin), ~(keys.coin[3] | seat[3].coin)};
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			player_ports        <= '1; // Nothing pressed
			player_ports.sys[4] <= ~service;
		end else begin
			player_ports <= ports_d;
		end
	end

	// Service switch always passes through, reset included
	a_service: assert property (@(posedge clk_sys)
		##1 player_ports.sys[4] == ~$past(service));

endmodule

/* source/key_latch.sv */
/*
 PS/2 keyboard events to held key bits
 An event is any change of the toggle bit, the pressed bit is copied to the mapped key
 Vindicators Part II has its own map, every other game uses the Gauntlet map
*/
`timescale 1ns/100ps

module key_latch (
	input  logic                     clk_sys,
	input  logic                     rst,
	input  logic [10:0]              ps2_key,
	input  gauntlet_pkg::game_type_e game_type,
	output gauntlet_pkg::key_state_t keys
);

	logic toggle_q;
	logic pressed;

	assign pressed = ps2_key[9];

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			toggle_q <= ps2_key[10]; // No event out of reset
			keys     <= '0;
		end else begin
			toggle_q <= ps2_key[10];
			if (toggle_q != ps2_key[10]) begin
				if (game_type == gauntlet_pkg::GT_VINDICATORS2) begin
					case (ps2_key[8:0])
						9'h023: keys.kp1[7] <= pressed; // R back (D)
						9'h01B: keys.kp1[6] <= pressed; // L back (S)
						9'h024: keys.kp1[5] <= pressed; // R forward (E)
						9'h01D: keys.kp1[4] <= pressed; // L forward (W)
						9'h02D: keys.kp1[3] <= pressed; // R thumb (R)
						9'h015: keys.kp1[2] <= pressed; // L thumb (Q)
						9'h02B: keys.kp1[1] <= pressed; // R trigger (F)
						9'h01C: keys.kp1[0] <= pressed; // L trigger (A)
						9'h042: keys.kp2[7] <= pressed; // K
						9'h03B: keys.kp2[6] <= pressed; // J
						9'h043: keys.kp2[5] <= pressed; // I
						9'h03C: keys.kp2[4] <= pressed; // U
						9'h044: keys.kp2[3] <= pressed; // O
						9'h035: keys.kp2[2] <= pressed; // Y
						9'h04B: keys.kp2[1] <= pressed; // L
						9'h033: keys.kp2[0] <= pressed; // H
						9'h016: keys.kp3[0] <= pressed; // P1 start (1)
						9'h01E: keys.kp3[1] <= pressed; // P2 start (2)
						9'h02E: keys.coin[0] <= pressed; // 5
						9'h036: keys.coin[1] <= pressed; // 6
						default: ;
					endcase
				end else begin
					case (ps2_key[8:0])
						// Player 1 on arrows and left modifiers
						9'h175: keys.kp1[7] <= pressed;
						9'h172: keys.kp1[6] <= pressed;
						9'h16B: keys.kp1[5] <= pressed;
						9'h174: keys.kp1[4] <= pressed;
						9'h014: keys.kp1[1] <= pressed; // Fire, left Ctrl
						9'h011: keys.kp1[0] <= pressed; // Magic, left Alt
						9'h02D: keys.kp2[7] <= pressed; // R
						9'h02B: keys.kp2[6] <= pressed; // F
						9'h023: keys.kp2[5] <= pressed; // D
						9'h034: keys.kp2[4] <= pressed; // G
						9'h01C: keys.kp2[1] <= pressed; // A
						9'h01B: keys.kp2[0] <= pressed; // S
						9'h043: keys.kp3[7] <= pressed; // I
						9'h042: keys.kp3[6] <= pressed; // K
						9'h03B: keys.kp3[5] <= pressed; // J
						9'h04B: keys.kp3[4] <= pressed; // L
						9'h114: keys.kp3[1] <= pressed; // Right Ctrl
						9'h059: keys.kp3[0] <= pressed; // Right Shift
						// Player 4 on the numpad
						9'h075: keys.kp4[7] <= pressed;
						9'h072: keys.kp4[6] <= pressed;
						9'h06B: keys.kp4[5] <= pressed;
						9'h074: keys.kp4[4] <= pressed;
						9'h070: keys.kp4[1] <= pressed; // Numpad 0
						9'h071: keys.kp4[0] <= pressed; // Numpad .
						9'h02E: keys.coin[0] <= pressed; // 5
						9'h036: keys.coin[1] <= pressed; // 6
						9'h03D: keys.coin[2] <= pressed; // 7
						9'h03E: keys.coin[3] <= pressed; // 8
						default: ;
					endcase
				end
			end
		end
	end

endmodule

/* source/game_rom_store.sv */
/*
 ROM store for the game CPU, audio CPU and character generator
 Nine banks written from one record stream
 Program bus decodes 32K word blocks 0, 4..7 and the 16K block at 0x18000
 Unmapped program reads return zero one cycle after the address
*/
`timescale 1ns/100ps

module game_rom_store #(
	parameter int ROM_AW_MP = 15
) (
	input  logic                  clk_sys,
	input  logic                  rst,
	input  gauntlet_pkg::rom_wr_t rom_wr,
	input  logic [18:0]           mp_addr,
	output logic [15:0]           mp_data,
	input  logic [15:0]           ap_addr,
	output logic [7:0]            ap_data,
	input  logic [13:0]           cp_addr,
	output logic [7:0]            cp_data
);

	// Full size program banks and their 32K word blocks
	localparam gauntlet_pkg::rom_region_e MP_REG [5] = '{gauntlet_pkg::REG_MP_9AB,
		gauntlet_pkg::REG_MP_7AB, gauntlet_pkg::REG_MP_6AB, gauntlet_pkg::REG_MP_5AB,
		gauntlet_pkg::REG_MP_3AB};
	localparam int MP_BLK [5] = '{0, 4, 5, 6, 7};

	logic [15:0] mp_q [5];
	logic [15:0] mp_10ab_q;
	logic [7:0]  ap_16s_q;
	logic [7:0]  ap_16r_q;
	gauntlet_pkg::rom_region_e mp_sel; // Bank of the read in flight
	logic ap_sel;

	// ##################################################
	// Banks
	// ##################################################
	for (genvar i = 0; i < 5; i++) begin : g_mp
		rom_bank #(.AW(ROM_AW_MP), .DW(16)) bank_inst (
			.clk_sys (clk_sys),
			.wr_en   (rom_wr.valid && rom_wr.region == MP_REG[i]),
			.wr_addr (rom_wr.addr),
			.wr_data (rom_wr.data),
			.rd_addr (mp_addr[ROM_AW_MP-1:0]),
			.rd_data (mp_q[i])
		);
	end

	rom_bank #(.AW(ROM_AW_MP-1), .DW(16)) mp_10ab_inst ( // Half size pair
		.clk_sys (clk_sys),
		.wr_en   (rom_wr.valid && rom_wr.region == gauntlet_pkg::REG_MP_10AB),
		.wr_addr (rom_wr.addr),
		.wr_data (rom_wr.data),
		.rd_addr (mp_addr[ROM_AW_MP-2:0]),
		.rd_data (mp_10ab_q)
	);

	rom_bank #(.AW(15), .DW(8)) ap_16s_inst (
		.clk_sys (clk_sys),
		.wr_en   (rom_wr.valid && rom_wr.region == gauntlet_pkg::REG_AP_16S),
		.wr_addr (rom_wr.addr),
		.wr_data (rom_wr.data[7:0]),
		.rd_addr (ap_addr[14:0]),
		.rd_data (ap_16s_q)
	);

	rom_bank #(.AW(14), .DW(8)) ap_16r_inst (
		.clk_sys (clk_sys),
		.wr_en   (rom_wr.valid && rom_wr.region == gauntlet_pkg::REG_AP_16R),
		.wr_addr (rom_wr.addr),
		.wr_data (rom_wr.data[7:0]),
		.rd_addr (ap_addr[13:0]),
		.rd_data (ap_16r_q)
	);

	rom_bank #(.AW(14), .DW(8)) cp_6p_inst ( // Character ROM
		.clk_sys (clk_sys),
		.wr_en   (rom_wr.valid && rom_wr.region == gauntlet_pkg::REG_CP_6P),
		.wr_addr (rom_wr.addr),
		.wr_data (rom_wr.data[7:0]),
		.rd_addr (cp_addr),
		.rd_data (cp_data)
	);

	// ##################################################
	// Read selects, aligned with the bank read
	// ##################################################
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			mp_sel <= gauntlet_pkg::REG_NONE;
			ap_sel <= 1'b0;
		end else begin
			mp_sel <= gauntlet_pkg::REG_NONE; // Reads as zero
			if ((mp_addr >> (ROM_AW_MP-1)) == 19'd6)
				mp_sel <= gauntlet_pkg::REG_MP_10AB; // 0x18000..0x1BFFF
			for (int i = 0; i < 5; i++)
				if ((mp_addr >> ROM_AW_MP) == 19'(MP_BLK[i]))
					mp_sel <= MP_REG[i];
			ap_sel <= ap_addr[15]; // 1 picks 16S
		end
	end

	always_comb begin
		mp_data = '0;
		for (int i = 0; i < 5; i++)
			if (mp_sel == MP_REG[i])
				mp_data = mp_q[i];
		if (mp_sel == gauntlet_pkg::REG_MP_10AB)
			mp_data = mp_10ab_q;
	end

	assign ap_data = ap_sel ? ap_16s_q : ap_16r_q;

endmodule

/* source/rom_download.sv */
/*
 Loader byte stream to ROM write records
 Program words pair two bytes, the earlier one is the high byte
 Word writes happen on odd addresses only, bytes outside all regions are dropped
 No back-pressure, one byte per ioctl_wr strobe
*/
`timescale 1ns/100ps

module rom_download (
	input  logic                     clk_sys,
	input  logic                     rst,
	input  logic                     ioctl_download,
	input  logic                     ioctl_wr,
	input  logic [7:0]               ioctl_index,
	input  logic [24:0]              ioctl_addr,
	input  logic [7:0]               ioctl_dout,
	output gauntlet_pkg::rom_wr_t    rom_wr,
	output gauntlet_pkg::game_type_e game_type
);

	gauntlet_pkg::rom_region_e region;
	logic [gauntlet_pkg::REC_AW-1:0] rec_addr;
	logic [7:0] prev_byte; // High byte of the next word
	logic rom_strobe;
	logic is_byte;
	logic accept;

	// Address map decode
	always_comb begin
		region = gauntlet_pkg::REG_NONE; // Filler gaps too
		if (ioctl_addr[24:16] == gauntlet_pkg::LDR_MP_9AB[24:16])
			region = gauntlet_pkg::REG_MP_9AB;
		else if (ioctl_addr[24:15] == gauntlet_pkg::LDR_MP_10AB[24:15])
			region = gauntlet_pkg::REG_MP_10AB;
		else if (ioctl_addr[24:16] == gauntlet_pkg::LDR_MP_7AB[24:16])
			region = gauntlet_pkg::REG_MP_7AB;
		else if (ioctl_addr[24:16] == gauntlet_pkg::LDR_MP_6AB[24:16])
			region = gauntlet_pkg::REG_MP_6AB;
		else if (ioctl_addr[24:16] == gauntlet_pkg::LDR_MP_5AB[24:16])
			region = gauntlet_pkg::REG_MP_5AB;
		else if (ioctl_addr[24:16] == gauntlet_pkg::LDR_MP_3AB[24:16])
			region = gauntlet_pkg::REG_MP_3AB;
		else if (ioctl_addr[24:15] == gauntlet_pkg::LDR_AP_16S[24:15])
			region = gauntlet_pkg::REG_AP_16S;
		else if (ioctl_addr[24:14] == gauntlet_pkg::LDR_AP_16R[24:14])
			region = gauntlet_pkg::REG_AP_16R;
		else if (ioctl_addr[24:14] == gauntlet_pkg::LDR_CP_6P[24:14])
			region = gauntlet_pkg::REG_CP_6P;

		case (region)
			gauntlet_pkg::REG_AP_16S: rec_addr = ioctl_addr[14:0];
			gauntlet_pkg::REG_AP_16R,
			gauntlet_pkg::REG_CP_6P:  rec_addr = {1'b0, ioctl_addr[13:0]};
			default:                  rec_addr = ioctl_addr[15:1]; // Word address
		endcase
	end

	assign rom_strobe = ioctl_wr && ioctl_download && ioctl_index == 8'd0;
	assign is_byte = region inside {gauntlet_pkg::REG_AP_16S, gauntlet_pkg::REG_AP_16R,
		gauntlet_pkg::REG_CP_6P};
	assign accept = rom_strobe && region != gauntlet_pkg::REG_NONE && (is_byte || ioctl_addr[0]);

	// Payload
	always_ff @(posedge clk_sys) begin
		if (rom_strobe)
			prev_byte <= ioctl_dout;
		if (accept) begin
			rom_wr.region <= region;
			rom_wr.addr   <= rec_addr;
			rom_wr.data   <= {prev_byte, ioctl_dout}; // Byte banks take the low half
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			rom_wr.valid <= 1'b0;
			game_type    <= gauntlet_pkg::GT_GAUNTLET;
		end else begin
			rom_wr.valid <= accept;
			if (ioctl_wr && ioctl_index == 8'd1)
				game_type <= gauntlet_pkg::game_type_e'(ioctl_dout); // Index 1 byte
		end
	end

	// Records only come from bytes sent during a download
	a_valid_in_download: assert property (@(posedge clk_sys) disable iff (rst)
		rom_wr.valid |-> $past(ioctl_download));

endmodule

/* source/rom_bank.sv */
/*
 Single ROM chip pair store, one write port and one registered read port
 Write address is the full record address, only AW bits are used
 No read enable, data follows the address by one cycle
*/
`timescale 1ns/100ps

module rom_bank #(
	parameter int AW = 14,
	parameter int DW = 8
) (
	input  logic                            clk_sys,
	input  logic                            wr_en,
	input  logic [gauntlet_pkg::REC_AW-1:0] wr_addr,
	input  logic [DW-1:0]                   wr_data,
	input  logic [AW-1:0]                   rd_addr,
	output logic [DW-1:0]                   rd_data
);

	logic [DW-1:0] mem [2**AW];

	always_ff @(posedge clk_sys) begin
		if (wr_en)
			mem[wr_addr[AW-1:0]] <= wr_data;
		rd_data <= mem[rd_addr]; // Registered read
	end

	// Decoder upstream keeps addresses inside the bank
	a_addr_fits: assert property (@(posedge clk_sys) wr_en |-> (wr_addr >> AW) == '0);

endmodule

/* source/gauntlet_pkg.sv */
/*
 Shared types and loader address map of the Gauntlet host glue
 Loader addresses are byte addresses of the index 0 stream
 Program regions hold 16-bit words, audio and character regions hold bytes
 Game type values are the protection chip numbers that the core expects
*/
package gauntlet_pkg;

	// ##################################################
	// Game and region codes
	// ##################################################
	typedef enum logic [7:0] {
		GT_GAUNTLET     = 8'd104, // Four players
		GT_GAUNTLET2    = 8'd106, // Four players
		GT_GAUNTLET_2P  = 8'd107,
		GT_VINDICATORS2 = 8'd118  // Tank controls
	} game_type_e;

	typedef enum logic [3:0] {
		REG_NONE, REG_MP_9AB, REG_MP_10AB, REG_MP_7AB, REG_MP_6AB,
		REG_MP_5AB, REG_MP_3AB, REG_AP_16S, REG_AP_16R, REG_CP_6P
	} rom_region_e;

	// ##################################################
	// Loader map
	// ##################################################
	localparam int LDR_ADDR_W = 25;
	localparam int REC_AW     = 15; // Record address width
	localparam logic [LDR_ADDR_W-1:0] LDR_MP_9AB  = 25'h0C_0000; // 64KB
	localparam logic [LDR_ADDR_W-1:0] LDR_MP_10AB = 25'h0F_0000; // 32KB
	localparam logic [LDR_ADDR_W-1:0] LDR_MP_7AB  = 25'h10_0000;
	localparam logic [LDR_ADDR_W-1:0] LDR_MP_6AB  = 25'h11_0000;
	localparam logic [LDR_ADDR_W-1:0] LDR_MP_5AB  = 25'h12_0000;
	localparam logic [LDR_ADDR_W-1:0] LDR_MP_3AB  = 25'h13_0000;
	localparam logic [LDR_ADDR_W-1:0] LDR_AP_16S  = 25'h14_0000; // 32KB
	localparam logic [LDR_ADDR_W-1:0] LDR_AP_16R  = 25'h14_8000; // 16KB
	localparam logic [LDR_ADDR_W-1:0] LDR_CP_6P   = 25'h14_C000; // 16KB

	// ##################################################
	// Records
	// ##################################################
	typedef struct packed {
		logic              valid;
		rom_region_e       region;
		logic [REC_AW-1:0] addr;   // Word or byte address
		logic [15:0]       data;   // Byte regions use the low byte
	} rom_wr_t;

	// One joystick, right in bit 0
	typedef struct packed {
		logic start;
		logic coin;
		logic button4;
		logic button3;
		logic button2;
		logic button1;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_t;

	typedef struct packed {
		logic [1:0] elf;
		logic [1:0] wizard;
		logic [1:0] valkyrie;
		logic [1:0] warrior; // Seat 0
	} seat_map_t;

	typedef struct packed {
		logic [7:0] kp1;
		logic [7:0] kp2;
		logic [7:0] kp3;
		logic [7:0] kp4;
		logic [3:0] coin; // Coin 1 in bit 0
	} key_state_t;

	// All active low
	typedef struct packed {
		logic [7:0] p1;
		logic [7:0] p2;
		logic [7:0] p3;
		logic [7:0] p4;
		logic [4:0] sys; // service_n, coin1_n .. coin4_n
	} player_ports_t;

endpackage
